/* common/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Data and address width of the stage.
`define EX_XLEN 32

// Word address width of the data RAM, 256 words.
`define EX_RAM_AW 8

`endif

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b    // LUI.
  } alu_op_t;

  typedef enum logic [2:0] {
    md_mul,
    md_mulh,
    md_mulhsu,
    md_mulhu,
    md_div,
    md_divu,
    md_rem,
    md_remu
  } md_op_t;

  typedef enum logic [2:0] {
    lsu_lb,
    lsu_lh,
    lsu_lw,
    lsu_lbu,
    lsu_lhu,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_t;

  // Class of an issued instruction.
  typedef enum logic [2:0] {
    unit_alu,
    unit_auipc,
    unit_jump,      // JAL and JALR link.
    unit_muldiv,
    unit_load,
    unit_store,
    unit_illegal
  } unit_t;

  // RISC-V mcause values.
  typedef enum logic [3:0] {
    exc_illegal_instruction = 4'd2,
    exc_load_misaligned     = 4'd4,
    exc_store_misaligned    = 4'd6
  } ecause_t;

endpackage

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none
`include "ex_macros.svh"

package pipe_pkg;

  typedef struct packed {
    logic                valid;
    isa_pkg::unit_t      unit;
    isa_pkg::alu_op_t    alu_op;
    isa_pkg::md_op_t     md_op;
    isa_pkg::lsu_op_t    lsu_op;
    logic [`EX_XLEN-1:0] pc;
    logic [`EX_XLEN-1:0] rdata1;
    logic [`EX_XLEN-1:0] rdata2;
    logic [`EX_XLEN-1:0] imm;
    logic                use_imm;   // Second operand is imm.
    logic [4:0]          rd;
    logic [31:0]         instr;
  } issue_t;

  typedef struct packed {
    logic                wren;
    logic [4:0]          waddr;
    logic [`EX_XLEN-1:0] wdata;
  } writeback_t;

  typedef struct packed {
    logic                valid;
    isa_pkg::ecause_t    cause;
    logic [`EX_XLEN-1:0] tval;
    logic [`EX_XLEN-1:0] epc;
  } except_t;

  typedef struct packed {
    isa_pkg::alu_op_t    op;
    logic [`EX_XLEN-1:0] rs1;
    logic [`EX_XLEN-1:0] rs2;
    logic [`EX_XLEN-1:0] imm;
    logic                use_imm;
  } alu_in_t;

  typedef struct packed {
    logic [`EX_XLEN-1:0] result;
  } alu_out_t;

  typedef struct packed {
    logic                start;
    isa_pkg::md_op_t     op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } md_in_t;

  typedef struct packed {
    logic                ready;
    logic [`EX_XLEN-1:0] result;
  } md_out_t;

  typedef struct packed {
    logic                valid;
    isa_pkg::lsu_op_t    op;
    logic [`EX_XLEN-1:0] addr;
    logic [`EX_XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                done;
    logic [`EX_XLEN-1:0] rdata;
  } lsu_rsp_t;

  // Wishbone classic, master to slave.
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`EX_XLEN-1:0] adr;
    logic [3:0]          sel;
    logic [`EX_XLEN-1:0] dat;
  } wb_m2s_t;

  typedef struct packed {
    logic                ack;
    logic [`EX_XLEN-1:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

/* execute/int_alu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module int_alu (
  input  pipe_pkg::alu_in_t  in,
  output pipe_pkg::alu_out_t out
);

  logic [`EX_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic                lt_s;
  logic                lt_u;

  assign op_b  = in.use_imm ? in.imm : in.rs2;
  assign shamt = op_b[4:0];   // RV32 uses five bits.
  assign lt_s  = $signed(in.rs1) < $signed(op_b);
  assign lt_u  = in.rs1 < op_b;

  always_comb begin
    case (in.op)
      isa_pkg::alu_add:    out.result = in.rs1 + op_b;
      isa_pkg::alu_sub:    out.result = in.rs1 - op_b;
      isa_pkg::alu_sll:    out.result = in.rs1 << shamt;
      isa_pkg::alu_slt:    out.result = {{(`EX_XLEN-1){1'b0}}, lt_s};
      isa_pkg::alu_sltu:   out.result = {{(`EX_XLEN-1){1'b0}}, lt_u};
      isa_pkg::alu_xor:    out.result = in.rs1 ^ op_b;
      isa_pkg::alu_srl:    out.result = in.rs1 >> shamt;
      isa_pkg::alu_sra:    out.result = $signed(in.rs1) >>> shamt;
      isa_pkg::alu_or:     out.result = in.rs1 | op_b;
      isa_pkg::alu_and:    out.result = in.rs1 & op_b;
      isa_pkg::alu_pass_b: out.result = op_b;
      default:             out.result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* execute/muldiv_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module muldiv_unit (
  input  logic              clk,
  input  logic              rst,
  input  pipe_pkg::md_in_t  in,
  output pipe_pkg::md_out_t out
);

  typedef enum logic [1:0] {md_idle, md_calc, md_fix} md_state_t;

  md_state_t               state;
  isa_pkg::md_op_t         op_q;
  logic [2*`EX_XLEN-1:0]   acc;       // {hi, lo}, product or {rem, quo}.
  logic [2*`EX_XLEN-1:0]   acc_neg;
  logic [`EX_XLEN-1:0]     b_abs;
  logic [`EX_XLEN-1:0]     a_q;
  logic                    neg_q;
  logic                    b_zero_q;
  logic [4:0]              cnt;
  logic                    a_neg;
  logic                    b_neg;
  logic                    start_neg;
  logic [`EX_XLEN-1:0]     a_abs_in;
  logic [`EX_XLEN-1:0]     b_abs_in;
  logic                    is_div;
  logic [`EX_XLEN:0]       mul_sum;
  logic [`EX_XLEN+1:0]     div_diff;
  logic [`EX_XLEN-1:0]     fix_result;
  logic                    ready_q;
  logic [`EX_XLEN-1:0]     result_q;

  always_comb begin
    a_neg = in.a[`EX_XLEN-1] &
            (in.op inside {isa_pkg::md_mulh, isa_pkg::md_mulhsu, isa_pkg::md_div, isa_pkg::md_rem});
    b_neg = in.b[`EX_XLEN-1] & (in.op inside {isa_pkg::md_mulh, isa_pkg::md_div, isa_pkg::md_rem});
    a_abs_in  = a_neg ? -in.a : in.a;
    b_abs_in  = b_neg ? -in.b : in.b;
    start_neg = (in.op inside {isa_pkg::md_rem, isa_pkg::md_remu}) ? a_neg : (a_neg ^ b_neg);
  end

  assign is_div   = op_q inside {isa_pkg::md_div, isa_pkg::md_divu,
                                 isa_pkg::md_rem, isa_pkg::md_remu};
  assign mul_sum  = {1'b0, acc[2*`EX_XLEN-1:`EX_XLEN]} + (acc[0] ? {1'b0, b_abs} : '0);
  assign div_diff = {1'b0, acc[2*`EX_XLEN-1:`EX_XLEN-1]} - {2'b00, b_abs};
  assign acc_neg  = -acc;

  // Sign fix and the x/0 results.
  always_comb begin
    case (op_q)
      isa_pkg::md_mul:
        fix_result = acc[`EX_XLEN-1:0];   // Low half is sign independent.
      isa_pkg::md_mulh, isa_pkg::md_mulhsu, isa_pkg::md_mulhu:
        fix_result = neg_q ? acc_neg[2*`EX_XLEN-1:`EX_XLEN] : acc[2*`EX_XLEN-1:`EX_XLEN];
      isa_pkg::md_div, isa_pkg::md_divu:
        fix_result = b_zero_q ? '1 : (neg_q ? -acc[`EX_XLEN-1:0] : acc[`EX_XLEN-1:0]);
      default:
        fix_result = b_zero_q ? a_q :
                     (neg_q ? -acc[2*`EX_XLEN-1:`EX_XLEN] : acc[2*`EX_XLEN-1:`EX_XLEN]);
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state   <= md_idle;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        md_idle: if (in.start) state <= md_calc;
        md_calc: if (&cnt) state <= md_fix;   // 32 steps.
        default: begin
          state   <= md_idle;
          ready_q <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      md_idle: begin
        if (in.start) begin
          op_q     <= in.op;
          a_q      <= in.a;
          b_abs    <= b_abs_in;
          neg_q    <= start_neg;
          b_zero_q <= (in.b == '0);
          acc      <= {{`EX_XLEN{1'b0}}, a_abs_in};
          cnt      <= '0;
        end
      end
      md_calc: begin
        cnt <= cnt + 5'd1;
        if (is_div) begin
          if (!div_diff[`EX_XLEN+1]) begin   // No borrow, quotient bit set.
            acc <= {div_diff[`EX_XLEN-1:0], acc[`EX_XLEN-2:0], 1'b1};
          end else begin
            acc <= {acc[2*`EX_XLEN-2:0], 1'b0};
          end
        end else begin
          acc <= {mul_sum, acc[`EX_XLEN-1:1]};
        end
      end
      default: result_q <= fix_result;
    endcase
  end

  assign out.ready  = ready_q;
  assign out.result = result_q;

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::issue_t     issue,
  output pipe_pkg::alu_in_t    alu_in,
  input  pipe_pkg::alu_out_t   alu_out,
  output pipe_pkg::md_in_t     md_in,
  input  pipe_pkg::md_out_t    md_out,
  output pipe_pkg::lsu_req_t   lsu_req,
  input  pipe_pkg::lsu_rsp_t   lsu_rsp,
  output pipe_pkg::writeback_t writeback,
  output pipe_pkg::except_t    exc,
  output logic                 stall
);

  typedef enum logic [1:0] {ph_first, ph_wait, ph_done} phase_t;

  pipe_pkg::issue_t    r;
  logic                valid_q;
  phase_t              phase;
  logic [`EX_XLEN-1:0] res_q;
  logic [`EX_XLEN-1:0] link;
  logic                is_mem;
  logic                addr_bad;
  logic                misaligned;
  logic                bad;
  logic                long_op;
  logic                unit_done;
  logic                wb_hit;

  assign is_mem     = (r.unit == isa_pkg::unit_load) || (r.unit == isa_pkg::unit_store);
  assign misaligned = is_mem & addr_bad;
  assign bad        = valid_q & ((r.unit == isa_pkg::unit_illegal) | misaligned);
  assign long_op    = valid_q & ~bad & ((r.unit == isa_pkg::unit_muldiv) | is_mem);
  assign stall      = long_op & (phase != ph_done);
  assign link       = r.pc + `EX_XLEN'(4);
  assign unit_done  = (r.unit == isa_pkg::unit_muldiv) ? md_out.ready : lsu_rsp.done;

  // Operands for the ALU, which also forms AUIPC and the load/store address.
  always_comb begin
    alu_in.op      = r.alu_op;
    alu_in.rs1     = r.rdata1;
    alu_in.rs2     = r.rdata2;
    alu_in.imm     = r.imm;
    alu_in.use_imm = r.use_imm;
    if (r.unit == isa_pkg::unit_auipc) begin
      alu_in.op      = isa_pkg::alu_add;
      alu_in.rs1     = r.pc;
      alu_in.use_imm = 1'b1;
    end else if (is_mem) begin
      alu_in.op      = isa_pkg::alu_add;
      alu_in.use_imm = 1'b1;
    end
  end

  always_comb begin
    case (r.lsu_op)
      isa_pkg::lsu_lh, isa_pkg::lsu_lhu, isa_pkg::lsu_sh: addr_bad = alu_out.result[0];
      isa_pkg::lsu_lw, isa_pkg::lsu_sw:                   addr_bad = |alu_out.result[1:0];
      default:                                            addr_bad = 1'b0;
    endcase
  end

  assign md_in.start = long_op & (r.unit == isa_pkg::unit_muldiv) & (phase == ph_first);
  assign md_in.op    = r.md_op;
  assign md_in.a     = r.rdata1;
  assign md_in.b     = r.rdata2;

  assign lsu_req.valid = long_op & is_mem & (phase == ph_first);
  assign lsu_req.op    = r.lsu_op;
  assign lsu_req.addr  = alu_out.result;
  assign lsu_req.wdata = r.rdata2;

  always_comb begin
    exc.valid = bad;
    exc.epc   = r.pc;
    if (r.unit == isa_pkg::unit_illegal) begin
      exc.cause = isa_pkg::exc_illegal_instruction;
      exc.tval  = r.instr;
    end else if (r.unit == isa_pkg::unit_store) begin
      exc.cause = isa_pkg::exc_store_misaligned;
      exc.tval  = alu_out.result;
    end else begin
      exc.cause = isa_pkg::exc_load_misaligned;
      exc.tval  = alu_out.result;
    end
  end

  always_comb begin
    writeback.waddr = r.rd;
    writeback.wdata = alu_out.result;
    case (r.unit)
      isa_pkg::unit_alu, isa_pkg::unit_auipc: wb_hit = 1'b1;
      isa_pkg::unit_jump: begin
        wb_hit          = 1'b1;
        writeback.wdata = link;
      end
      isa_pkg::unit_muldiv, isa_pkg::unit_load: begin
        wb_hit          = (phase == ph_done);   // Result captured last cycle.
        writeback.wdata = res_q;
      end
      default: wb_hit = 1'b0;
    endcase
    writeback.wren = valid_q & wb_hit & (r.rd != 5'd0) & ~stall & ~bad;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= 1'b0;
      phase   <= ph_first;
    end else begin
      if (!stall) begin
        valid_q <= issue.valid;
      end
      case (phase)
        ph_first: if (long_op) phase <= ph_wait;
        ph_wait:  if (unit_done) phase <= ph_done;
        default:  phase <= ph_first;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      r <= issue;
    end
    if ((phase == ph_wait) && unit_done) begin
      res_q <= (r.unit == isa_pkg::unit_muldiv) ? md_out.result : lsu_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module lsu (
  input  logic               clk,
  input  logic               rst,
  input  pipe_pkg::lsu_req_t req,
  output pipe_pkg::lsu_rsp_t rsp,
  output pipe_pkg::wb_m2s_t  wbm_o,
  input  pipe_pkg::wb_s2m_t  wbm_i
);

  isa_pkg::lsu_op_t    op_q;
  logic                cyc_q;
  logic                we_q;
  logic [`EX_XLEN-1:0] adr_q;
  logic [3:0]          sel_q;
  logic [`EX_XLEN-1:0] dat_q;
  logic                done_q;
  logic [`EX_XLEN-1:0] rdata_q;
  logic [3:0]          sel;
  logic                is_store;
  logic                launch;
  logic [`EX_XLEN-1:0] lane;
  logic [`EX_XLEN-1:0] load_data;

  assign is_store = req.op inside {isa_pkg::lsu_sb, isa_pkg::lsu_sh, isa_pkg::lsu_sw};
  assign launch   = req.valid & ~cyc_q;

  always_comb begin
    case (req.op)
      isa_pkg::lsu_lb, isa_pkg::lsu_lbu, isa_pkg::lsu_sb: sel = 4'b0001 << req.addr[1:0];
      isa_pkg::lsu_lh, isa_pkg::lsu_lhu, isa_pkg::lsu_sh: sel = 4'b0011 << req.addr[1:0];
      default:                                            sel = 4'b1111;
    endcase
  end

  assign lane = wbm_i.dat >> {adr_q[1:0], 3'b000};

  always_comb begin
    case (op_q)
      isa_pkg::lsu_lb:  load_data = {{(`EX_XLEN-8){lane[7]}}, lane[7:0]};
      isa_pkg::lsu_lbu: load_data = {{(`EX_XLEN-8){1'b0}}, lane[7:0]};
      isa_pkg::lsu_lh:  load_data = {{(`EX_XLEN-16){lane[15]}}, lane[15:0]};
      isa_pkg::lsu_lhu: load_data = {{(`EX_XLEN-16){1'b0}}, lane[15:0]};
      default:          load_data = lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (cyc_q & wbm_i.ack) begin
        cyc_q  <= 1'b0;   // Bus released the cycle after ack.
        done_q <= 1'b1;
      end else if (launch) begin
        cyc_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      op_q  <= req.op;
      we_q  <= is_store;
      adr_q <= req.addr;
      sel_q <= sel;
      dat_q <= req.wdata << {req.addr[1:0], 3'b000};
    end
    if (cyc_q & wbm_i.ack) begin
      rdata_q <= load_data;
    end
  end

  assign wbm_o.cyc = cyc_q;
  assign wbm_o.stb = cyc_q;
  assign wbm_o.we  = we_q;
  assign wbm_o.adr = adr_q;
  assign wbm_o.sel = sel_q;
  assign wbm_o.dat = dat_q;
  assign rsp.done  = done_q;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ex_macros.svh"

module data_ram (
  input  logic              clk,
  input  logic              rst,
  input  pipe_pkg::wb_m2s_t wbs_i,
  output pipe_pkg::wb_s2m_t wbs_o
);

  logic [`EX_XLEN-1:0]   mem [2**`EX_RAM_AW];
  logic [`EX_RAM_AW-1:0] word;
  logic [`EX_RAM_AW-1:0] clr_idx;
  logic                  clearing;
  logic                  ack_q;
  logic [`EX_XLEN-1:0]   dat_q;
  logic                  req;

  assign word = wbs_i.adr[`EX_RAM_AW+1:2];
  assign req  = wbs_i.cyc & wbs_i.stb & ~ack_q & ~clearing;   // Held off during sweep.

  always_ff @(posedge clk) begin
    if (!rst) begin
      clearing <= 1'b1;
      clr_idx  <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= req;
      if (clearing) begin
        clr_idx <= clr_idx + 1'b1;
        if (&clr_idx) clearing <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clr_idx] <= '0;
    end else if (req && wbs_i.we) begin
      for (int i = 0; i < 4; i++) begin
        if (wbs_i.sel[i]) mem[word][8*i +: 8] <= wbs_i.dat[8*i +: 8];
      end
    end
    dat_q <= mem[word];
  end

  assign wbs_o.ack = ack_q;
  assign wbs_o.dat = dat_q;

endmodule

`default_nettype wire

/* verilog/execute_top.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_top (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::issue_t     issue,
  output pipe_pkg::writeback_t writeback,
  output pipe_pkg::except_t    exc,
  output logic                 stall
);

  pipe_pkg::alu_in_t  alu_in;
  pipe_pkg::alu_out_t alu_out;
  pipe_pkg::md_in_t   md_in;
  pipe_pkg::md_out_t  md_out;
  pipe_pkg::lsu_req_t lsu_req;
  pipe_pkg::lsu_rsp_t lsu_rsp;
  pipe_pkg::wb_m2s_t  wb_m2s;
  pipe_pkg::wb_s2m_t  wb_s2m;

  execute_stage u_stage (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .alu_in    (alu_in),
    .alu_out   (alu_out),
    .md_in     (md_in),
    .md_out    (md_out),
    .lsu_req   (lsu_req),
    .lsu_rsp   (lsu_rsp),
    .writeback (writeback),
    .exc       (exc),
    .stall     (stall)
  );

  int_alu u_alu (
    .in  (alu_in),
    .out (alu_out)
  );

  muldiv_unit u_muldiv (
    .clk (clk),
    .rst (rst),
    .in  (md_in),
    .out (md_out)
  );

  lsu u_lsu (
    .clk   (clk),
    .rst   (rst),
    .req   (lsu_req),
    .rsp   (lsu_rsp),
    .wbm_o (wb_m2s),
    .wbm_i (wb_s2m)
  );

  data_ram u_ram (
    .clk   (clk),
    .rst   (rst),
    .wbs_i (wb_m2s),
    .wbs_o (wb_s2m)
  );

endmodule

`default_nettype wire

/* verification/execute_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_checker (
  input logic                 clk,
  input logic                 rst,
  input pipe_pkg::wb_m2s_t    wb_m2s,
  input pipe_pkg::wb_s2m_t    wb_s2m,
  input pipe_pkg::writeback_t writeback,
  input pipe_pkg::except_t    exc
);

  int unsigned err_count;   // Failed rules so far.

  initial err_count = 0;

  stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst)
    wb_m2s.stb |-> wb_m2s.cyc)
    else begin
      $error("Wishbone stb high without cyc");
      err_count = err_count + 1;
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (!rst)
    wb_s2m.ack |-> wb_m2s.stb)
    else begin
      $error("Wishbone ack outside a strobe");
      err_count = err_count + 1;
    end

  no_write_x0: assert property (@(posedge clk) disable iff (!rst)
    writeback.wren |-> (writeback.waddr != 5'd0))
    else begin
      $error("Write-back to register x0");
      err_count = err_count + 1;
    end

  wb_or_exc: assert property (@(posedge clk) disable iff (!rst)
    !(writeback.wren && exc.valid))
    else begin
      $error("Write-back and exception in the same cycle");
      err_count = err_count + 1;
    end

  // Request fields frozen while waiting for ack.
  req_stable: assert property (@(posedge clk) disable iff (!rst)
    (wb_m2s.cyc && wb_m2s.stb && !wb_s2m.ack) |=>
      (wb_m2s.cyc && wb_m2s.stb && $stable(wb_m2s.adr) && $stable(wb_m2s.we) &&
       $stable(wb_m2s.sel) && $stable(wb_m2s.dat)))
    else begin
      $error("Wishbone request changed before ack");
      err_count = err_count + 1;
    end

endmodule

bind execute_top execute_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .wb_m2s    (wb_m2s),
  .wb_s2m    (wb_s2m),
  .writeback (writeback),
  .exc       (exc)
);

`default_nettype wire

/* verification/execute_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_tb;

  localparam int N_INSTR = 356;

  logic                 clk;
  logic                 rst;
  pipe_pkg::issue_t     issue;
  pipe_pkg::writeback_t writeback;
  pipe_pkg::except_t    exc;
  logic                 stall;
  logic [31:0]          rng;
  logic [7:0]           shadow [1024];   // Byte image of the low RAM.

  execute_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .writeback (writeback),
    .exc       (exc),
    .stall     (stall)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] alu_ref(input isa_pkg::alu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      isa_pkg::alu_add:  return a + b;
      isa_pkg::alu_sub:  return a - b;
      isa_pkg::alu_sll:  return a << b[4:0];
      isa_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      isa_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      isa_pkg::alu_xor:  return a ^ b;
      isa_pkg::alu_srl:  return a >> b[4:0];
      isa_pkg::alu_sra:  return 32'($signed(a) >>> b[4:0]);
      isa_pkg::alu_or:   return a | b;
      isa_pkg::alu_and:  return a & b;
      default:           return b;   // LUI.
    endcase
  endfunction

  function automatic logic [31:0] md_ref(input isa_pkg::md_op_t op, input logic [31:0] a,
                                         input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub;
    logic [63:0]        prod;
    logic               ovf;
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    ub   = {32'd0, b};
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    prod = 64'd0;
    case (op)
      isa_pkg::md_mul, isa_pkg::md_mulh: prod = sa * sb;
      isa_pkg::md_mulhsu:                prod = sa * ub;
      isa_pkg::md_mulhu:                 prod = {32'd0, a} * {32'd0, b};
      default:                           prod = 64'd0;
    endcase
    case (op)
      isa_pkg::md_mul:  return prod[31:0];
      isa_pkg::md_div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'($signed(a) / $signed(b)));
      isa_pkg::md_divu: return (b == 0) ? 32'hffff_ffff : a / b;
      isa_pkg::md_rem:  return (b == 0) ? a : (ovf ? 32'd0 : 32'($signed(a) % $signed(b)));
      isa_pkg::md_remu: return (b == 0) ? a : a % b;
      default:          return prod[63:32];
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input isa_pkg::lsu_op_t op, input logic [9:0] addr);
    logic [31:0] w;
    w = {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
    case (op)
      isa_pkg::lsu_lb:  return {{24{w[7]}}, w[7:0]};
      isa_pkg::lsu_lbu: return {24'd0, w[7:0]};
      isa_pkg::lsu_lh:  return {{16{w[15]}}, w[15:0]};
      isa_pkg::lsu_lhu: return {16'd0, w[15:0]};
      default:          return w;
    endcase
  endfunction

  function automatic pipe_pkg::issue_t make_issue(input isa_pkg::unit_t unit, input logic [4:0] rd);
    pipe_pkg::issue_t ins;
    ins         = '0;
    ins.valid   = 1'b1;
    ins.unit    = unit;
    ins.rd      = rd;
    ins.pc      = {next_rand() & 32'h000f_fffc};
    ins.rdata1  = next_rand();
    ins.rdata2  = next_rand();
    ins.imm     = next_rand();
    ins.instr   = next_rand();
    return ins;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    $display("Testbench failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_plain(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "check failed");
  endtask

  // Drive on the falling edge, hold while stalled, return when the result is visible.
  task automatic run_op(input pipe_pkg::issue_t ins);
    issue = ins;
    @(negedge clk);
    while (stall) @(negedge clk);
    issue.valid = 1'b0;
  endtask

  task automatic run_mem(input isa_pkg::unit_t unit, input isa_pkg::lsu_op_t op,
                         input logic [31:0] addr, input logic [31:0] data, input logic [4:0] rd);
    pipe_pkg::issue_t ins;
    logic [31:0]      off;
    ins        = make_issue(unit, rd);
    off        = next_rand();
    off        = {{28{off[3]}}, off[3:0]};
    ins.lsu_op = op;
    ins.imm    = off;
    ins.rdata1 = addr - off;
    ins.rdata2 = data;
    run_op(ins);
  endtask

  task automatic expect_wb(input string name, input logic [4:0] rd, input logic [31:0] data);
    assert (writeback.wren === (rd != 5'd0))
      else fail_value({name, " wren"}, 32'(rd != 5'd0), 32'(writeback.wren));
    if (rd != 5'd0) begin
      assert (writeback.waddr === rd) else fail_value({name, " waddr"}, rd, writeback.waddr);
      assert (writeback.wdata === data) else fail_value(name, data, writeback.wdata);
    end
    assert (exc.valid === 1'b0) else fail_plain({name, ": unexpected exception raised"});
  endtask

  task automatic expect_exc(input string name, input isa_pkg::ecause_t cause,
                            input logic [31:0] tval, input logic [31:0] epc);
    assert (exc.valid === 1'b1) else fail_plain({name, ": expected exception did not occur"});
    assert (exc.cause === cause) else fail_value({name, " cause"}, cause, exc.cause);
    assert (exc.tval === tval) else fail_value({name, " tval"}, tval, exc.tval);
    assert (exc.epc === epc) else fail_value({name, " epc"}, epc, exc.epc);
    assert (writeback.wren === 1'b0) else fail_plain({name, ": write-back on exception"});
    assert (u_dut.wb_m2s.cyc === 1'b0) else fail_plain({name, ": bus cycle on exception"});
  endtask

  initial begin
    repeat (N_INSTR * 40) @(posedge clk);
    $display("Watchdog timeout: the DUT did not finish the tests in time");
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  // Rules watched by the bound checker.
  always @(negedge clk) begin
    if (u_dut.u_checker.err_count != 0) begin
      fail_plain("A bus or write-back rule assertion failed");
    end
  end

  initial begin
    pipe_pkg::issue_t ins;
    logic [31:0]      r;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      addr;
    isa_pkg::lsu_op_t lop;
    issue = '0;
    rst   = 1'b0;
    rng   = 32'h409c;
    for (int i = 0; i < 1024; i++) shadow[i] = 8'h00;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    assert (stall === 1'b0 && writeback.wren === 1'b0 && exc.valid === 1'b0 &&
            u_dut.wb_m2s.cyc === 1'b0 && u_dut.wb_s2m.ack === 1'b0 &&
            u_dut.md_out.ready === 1'b0)
      else fail_plain("Control outputs not low after reset");

    // Reset contents.
    for (int i = 0; i < 8; i++) begin
      addr = next_rand() & 32'h3fc;
      run_mem(isa_pkg::unit_load, isa_pkg::lsu_lw, addr, 32'd0, 5'd1 + 5'(i));
      expect_wb("reset_lw", 5'd1 + 5'(i), 32'd0);
    end

    for (int i = 0; i < 200; i++) begin
      ins         = make_issue(isa_pkg::unit_alu, 5'(next_rand()));
      ins.alu_op  = isa_pkg::alu_op_t'(4'(next_rand() % 11));
      r           = next_rand();
      ins.use_imm = r[0];
      b           = ins.use_imm ? ins.imm : ins.rdata2;
      run_op(ins);
      expect_wb("alu", ins.rd, alu_ref(ins.alu_op, ins.rdata1, b));
    end
    ins     = make_issue(isa_pkg::unit_auipc, 5'd5);
    ins.imm = ins.imm & 32'hffff_f000;
    run_op(ins);
    expect_wb("auipc", 5'd5, ins.pc + ins.imm);
    ins = make_issue(isa_pkg::unit_jump, 5'd1);
    run_op(ins);
    expect_wb("jal", 5'd1, ins.pc + 32'd4);

    for (int j = 0; j < 8; j++) begin
      for (int k = 0; k < 6; k++) begin
        ins       = make_issue(isa_pkg::unit_muldiv, 5'd10 + 5'(k));
        ins.md_op = isa_pkg::md_op_t'(3'(j));
        if (k == 4) ins.rdata2 = 32'd0;
        if (k == 5) begin
          ins.rdata1 = 32'h8000_0000;
          ins.rdata2 = 32'hffff_ffff;
        end
        run_op(ins);
        expect_wb("muldiv", ins.rd, md_ref(ins.md_op, ins.rdata1, ins.rdata2));
      end
    end

    for (int i = 0; i < 40; i++) begin
      r    = next_rand();
      lop  = (r % 3 == 0) ? isa_pkg::lsu_sb : ((r % 3 == 1) ? isa_pkg::lsu_sh : isa_pkg::lsu_sw);
      addr = next_rand() & 32'h3f;
      if (lop == isa_pkg::lsu_sh) addr = addr & 32'h3e;
      if (lop == isa_pkg::lsu_sw) addr = addr & 32'h3c;
      a    = next_rand();
      run_mem(isa_pkg::unit_store, lop, addr, a, 5'd7);
      expect_wb("store", 5'd0, 32'd0);
      shadow[addr] = a[7:0];
      if (lop != isa_pkg::lsu_sb) shadow[addr + 1] = a[15:8];
      if (lop == isa_pkg::lsu_sw) begin
        shadow[addr + 2] = a[23:16];
        shadow[addr + 3] = a[31:24];
      end
    end

    for (int i = 0; i < 2; i++) begin
      addr = (next_rand() & 32'h3e) | 32'd1;
      run_mem(isa_pkg::unit_load, isa_pkg::lsu_lh, addr, 32'd0, 5'd3);
      expect_exc("lh_misaligned", isa_pkg::exc_load_misaligned, addr, issue.pc);
      addr = (next_rand() & 32'h3c) | (32'd1 + next_rand() % 3);
      run_mem(isa_pkg::unit_load, isa_pkg::lsu_lw, addr, 32'd0, 5'd3);
      expect_exc("lw_misaligned", isa_pkg::exc_load_misaligned, addr, issue.pc);
      addr = (next_rand() & 32'h3e) | 32'd1;
      run_mem(isa_pkg::unit_store, isa_pkg::lsu_sh, addr, next_rand(), 5'd3);
      expect_exc("sh_misaligned", isa_pkg::exc_store_misaligned, addr, issue.pc);
      addr = (next_rand() & 32'h3c) | (32'd1 + next_rand() % 3);
      run_mem(isa_pkg::unit_store, isa_pkg::lsu_sw, addr, next_rand(), 5'd3);
      expect_exc("sw_misaligned", isa_pkg::exc_store_misaligned, addr, issue.pc);
      ins = make_issue(isa_pkg::unit_illegal, 5'd4);
      run_op(ins);
      expect_exc("illegal", isa_pkg::exc_illegal_instruction, ins.instr, ins.pc);
    end

    // Read back through every load op.
    for (int j = 0; j < 5; j++) begin
      lop = isa_pkg::lsu_op_t'(3'(j));
      for (int i = 0; i < 8; i++) begin
        addr = next_rand() & 32'h3f;
        if (lop == isa_pkg::lsu_lh || lop == isa_pkg::lsu_lhu) addr = addr & 32'h3e;
        if (lop == isa_pkg::lsu_lw) addr = addr & 32'h3c;
        run_mem(isa_pkg::unit_load, lop, addr, 32'd0, 5'd20 + 5'(i));
        expect_wb("load", 5'd20 + 5'(i), load_ref(lop, addr[9:0]));
      end
    end

    for (int i = 0; i < 3; i++) begin
      ins        = make_issue(isa_pkg::unit_alu, 5'd0);
      ins.alu_op = isa_pkg::alu_op_t'(4'(next_rand() % 11));
      run_op(ins);
      expect_wb("x0_alu", 5'd0, 32'd0);
    end
    run_op(make_issue(isa_pkg::unit_auipc, 5'd0));
    expect_wb("x0_auipc", 5'd0, 32'd0);
    run_op(make_issue(isa_pkg::unit_jump, 5'd0));
    expect_wb("x0_jump", 5'd0, 32'd0);
    run_op(make_issue(isa_pkg::unit_muldiv, 5'd0));
    expect_wb("x0_mul", 5'd0, 32'd0);
    run_mem(isa_pkg::unit_load, isa_pkg::lsu_lw, 32'h10, 32'd0, 5'd0);
    expect_wb("x0_lw", 5'd0, 32'd0);
    run_mem(isa_pkg::unit_load, isa_pkg::lsu_lbu, 32'h21, 32'd0, 5'd0);
    expect_wb("x0_lbu", 5'd0, 32'd0);

    if (u_dut.u_checker.err_count != 0) begin
      fail_plain("A bus or write-back rule assertion failed");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
execute/int_alu.sv
execute/muldiv_unit.sv
execute/execute_stage.sv
verilog/lsu.sv
verilog/data_ram.sv
verilog/execute_top.sv
verification/execute_checker.sv
verification/execute_tb.sv

/* Bender.yml */
package:
  name: rv32_execute

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv
      - execute/int_alu.sv
      - execute/muldiv_unit.sv
      - execute/execute_stage.sv
      - verilog/lsu.sv
      - verilog/data_ram.sv
      - verilog/execute_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/execute_checker.sv
      - verification/execute_tb.sv
